// ==== tb/ibuf_patterns.mem ====
// each row is one cycle of eight hex fields
// test id, ctrl {init resteer br stall}, bank {miss_e miss_o wait_e wait_o},
// fip {e[1:0] o[1:0]}, new_bip, old_bip, flags {even odd}, valid after the edge

// reset, both banks blocked
1 0 C 0 00 00 0 0
1 0 C 0 00 00 0 0

// even into 00, odd into 11
2 0 0 3 00 00 3 9

// wait_e blocks 10 while odd fills 01
3 0 2 9 00 00 1 B
// miss_e blocks 10, odd pointer on an even slot
3 0 8 8 00 00 0 B
// miss_o, even still fills 10
3 0 4 B 00 00 2 F
// all valid so no reload
3 0 0 1 00 00 0 F
3 0 1 B 00 00 0 F

// init, resteer and br each clear everything
4 8 0 1 00 00 0 0
4 0 0 3 00 00 3 9
4 4 0 9 00 00 0 0
4 0 0 3 00 00 3 9
4 2 0 9 00 00 0 0
4 0 0 3 00 00 3 9
// stall holds valids through each flush, fills stay blocked
4 9 0 9 00 00 0 9
4 5 0 9 00 00 0 9
4 3 0 9 00 00 0 9

// refill 10, odd bank held off 01 by miss then wait
5 0 4 9 00 00 2 D
5 0 1 1 00 00 0 D
5 0 0 1 00 00 1 F
// wrap out of 00
5 0 C 0 12 0E 0 E
// no wrap, then equal offsets
5 0 C 0 18 13 0 E
5 0 C 0 25 15 0 E
// wrap out of 01 under stall, then without
5 1 C 0 21 1F 0 E
5 0 C 0 21 1F 0 C
// 00 already empty
5 0 C 0 13 0A 0 C
// wrap out of 11, then 10
5 0 C 0 01 3C 0 4
5 0 C 0 32 29 0 0

// ==== all.f ====
+incdir+include
rtl/ibuf_pkg.sv
rtl/ibuf_slot_control.sv
rtl/ibuf_line_bank.sv
rtl/ibuf_top.sv
tb/ibuf_tb.sv

// ==== Makefile ====
TOP := ibuf_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f all.f --top-module $(TOP)

# pass only if the run prints the pass line
sim:
	verilator --binary --timing --assert -f all.f --top-module $(TOP) -o ibuf_sim
	@out="$$(./obj_dir/ibuf_sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf obj_dir

// ==== tb/ibuf_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ibuf_cfg.svh"

module ibuf_tb;

    // eight byte-wide fields per pattern row
    localparam int FIELDS   = 8;
    localparam int MAX_ROWS = 64;

    // both banks missing, no flush, no stall
    localparam logic [63:0] IDLE_ROW = 64'h00_00_0C_00_00_00_00_00;

    logic clk_i = 1'b0;
    logic rst_n_i;

    // DUT inputs
    logic                is_br_t_nt_i;
    logic                is_resteer_i;
    logic                is_init_i;
    logic                stall_i;
    ibuf_pkg::line_t     line_even_i;
    ibuf_pkg::line_t     line_odd_i;
    ibuf_pkg::fip_lsb_t  fip_e_lsb_i;
    ibuf_pkg::fip_lsb_t  fip_o_lsb_i;
    logic                cache_miss_even_i;
    logic                cache_miss_odd_i;
    logic                even_wait_i;
    logic                odd_wait_i;
    ibuf_pkg::bip_t      new_bip_i;
    ibuf_pkg::bip_t      old_bip_i;

    // DUT outputs
    ibuf_pkg::line_t     line_00_o;
    ibuf_pkg::line_t     line_01_o;
    ibuf_pkg::line_t     line_10_o;
    ibuf_pkg::line_t     line_11_o;
    ibuf_pkg::slot_vec_t line_valid_o;
    logic                even_loaded_o;
    logic                odd_loaded_o;

    // pattern memory and line scoreboard
    logic [7:0]          pat [MAX_ROWS*FIELDS];
    ibuf_pkg::line_t     exp_line [`IBUF_SLOTS];
    ibuf_pkg::line_t     dut_line [`IBUF_SLOTS];
    ibuf_pkg::line_t     cur_even;
    ibuf_pkg::line_t     cur_odd;

    int n_rows;
    int limit = 1000;
    int cycles = 0;
    int seed;
    int test_errs;
    int total_errs;
    int tests_passed;
    int tests_failed;

    ibuf_top dut_i (
        .clk_i             (clk_i),
        .rst_n_i           (rst_n_i),
        .is_br_t_nt_i      (is_br_t_nt_i),
        .is_resteer_i      (is_resteer_i),
        .is_init_i         (is_init_i),
        .stall_i           (stall_i),
        .line_even_i       (line_even_i),
        .line_odd_i        (line_odd_i),
        .fip_e_lsb_i       (fip_e_lsb_i),
        .fip_o_lsb_i       (fip_o_lsb_i),
        .cache_miss_even_i (cache_miss_even_i),
        .cache_miss_odd_i  (cache_miss_odd_i),
        .even_wait_i       (even_wait_i),
        .odd_wait_i        (odd_wait_i),
        .new_bip_i         (new_bip_i),
        .old_bip_i         (old_bip_i),
        .line_00_o         (line_00_o),
        .line_01_o         (line_01_o),
        .line_10_o         (line_10_o),
        .line_11_o         (line_11_o),
        .line_valid_o      (line_valid_o),
        .even_loaded_o     (even_loaded_o),
        .odd_loaded_o      (odd_loaded_o)
    );

    // slot-indexed view of the line outputs
    assign dut_line[0] = line_00_o;
    assign dut_line[1] = line_01_o;
    assign dut_line[2] = line_10_o;
    assign dut_line[3] = line_11_o;

    // 40 ns clock
    always #20 clk_i = ~clk_i;

    // run limit in clock cycles
    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            $display("timeout after %0d cycles, the pattern run never completed", limit);
            $display("Test FAILED");
            $finish;
        end
    end

    // one row packed as {test, ctrl, bank, fip, new_bip, old_bip, flags, valid}
    function automatic logic [63:0] get_row(input int r);
        logic [63:0] row;
        for (int k = 0; k < FIELDS; k++) begin
            row[63-8*k -: 8] = pat[r*FIELDS+k];
        end
        return row;
    endfunction

    function automatic string test_name(input logic [3:0] t);
        case (t)
            4'd1:    return "reset";
            4'd2:    return "fill";
            4'd3:    return "miss and wait";
            4'd4:    return "flush and stall";
            4'd5:    return "boundary invalidation";
            default: return "unknown";
        endcase
    endfunction

    // 128 random bits, 32 at a time
    task automatic draw_line(output ibuf_pkg::line_t v);
        for (int i = 0; i < `IBUF_LINE_W / 32; i++) begin
            v[i*32 +: 32] = $random(seed);
        end
    endtask

    // apply one row to the DUT inputs, fresh line data every cycle
    task automatic drive_row(input logic [63:0] row);
        draw_line(cur_even);
        draw_line(cur_odd);
        is_init_i         <= row[51];
        is_resteer_i      <= row[50];
        is_br_t_nt_i      <= row[49];
        stall_i           <= row[48];
        cache_miss_even_i <= row[43];
        cache_miss_odd_i  <= row[42];
        even_wait_i       <= row[41];
        odd_wait_i        <= row[40];
        fip_e_lsb_i       <= row[35:34];
        fip_o_lsb_i       <= row[33:32];
        new_bip_i         <= row[29:24];
        old_bip_i         <= row[21:16];
        line_even_i       <= cur_even;
        line_odd_i        <= cur_odd;
    endtask

    // same-cycle loaded flags
    task automatic check_flags(input logic [63:0] row, input string where);
        assert (even_loaded_o === row[9]) else begin
            $display("MISMATCH even_loaded_o %s: expected %h, got %h",
                     where, row[9], even_loaded_o);
            test_errs++;
        end
        assert (odd_loaded_o === row[8]) else begin
            $display("MISMATCH odd_loaded_o %s: expected %h, got %h",
                     where, row[8], odd_loaded_o);
            test_errs++;
        end
    endtask

    // valids and lines one edge after the row
    task automatic check_state(input logic [63:0] row, input string where);
        ibuf_pkg::slot_vec_t exp_valid;
        ibuf_pkg::slot_e     sl;
        exp_valid = row[3:0];
        assert (line_valid_o === exp_valid) else begin
            $display("MISMATCH line_valid_o %s: expected %h, got %h",
                     where, exp_valid, line_valid_o);
            test_errs++;
        end
        for (int s = 0; s < `IBUF_SLOTS; s++) begin
            sl = ibuf_pkg::slot_e'(s[1:0]);
            assert (dut_line[s] === exp_line[s]) else begin
                $display("MISMATCH line_%0d%0d_o (%s) %s: expected %h, got %h",
                         s / 2, s % 2, sl.name(), where, exp_line[s], dut_line[s]);
                test_errs++;
            end
        end
    endtask

    // a taken line belongs in the slot its pointer names
    task automatic record_loads(input logic [63:0] row);
        if (row[9]) begin
            exp_line[row[35:34]] = cur_even;
        end
        if (row[8]) begin
            exp_line[row[33:32]] = cur_odd;
        end
    endtask

    task automatic finish_test(input logic [3:0] t);
        if (test_errs == 0) begin
            tests_passed++;
            $display("test %0d (%s) passed", t, test_name(t));
        end else begin
            tests_failed++;
            $display("test %0d (%s) failed with %0d mismatches", t, test_name(t), test_errs);
        end
        total_errs += test_errs;
        test_errs = 0;
    endtask

    initial begin
        logic [63:0] row;
        logic [3:0]  prev_test;
        seed         = 32'h97d2_792e;
        test_errs    = 0;
        total_errs   = 0;
        tests_passed = 0;
        tests_failed = 0;
        prev_test    = 4'd0;
        for (int s = 0; s < `IBUF_SLOTS; s++) begin
            exp_line[s] = '0;
        end
        for (int i = 0; i < MAX_ROWS * FIELDS; i++) begin
            pat[i] = 8'h00;
        end
        $readmemh("tb/ibuf_patterns.mem", pat);

        // rows end at the first zero test id
        n_rows = 0;
        while (n_rows < MAX_ROWS && pat[n_rows*FIELDS] != 8'h00) begin
            n_rows++;
        end
        if (n_rows == 0) begin
            $display("pattern file tb/ibuf_patterns.mem holds no rows");
            total_errs++;
        end
        limit = 4 + n_rows + 20;

        // reset for four cycles with the banks blocked
        rst_n_i <= 1'b0;
        drive_row(IDLE_ROW);
        repeat (4) @(posedge clk_i);
        rst_n_i <= 1'b1;
        @(negedge clk_i);
        check_flags(IDLE_ROW, "after reset");
        check_state(IDLE_ROW, "after reset");

        for (int r = 0; r < n_rows; r++) begin
            @(posedge clk_i);
            row = get_row(r);
            drive_row(row);
            @(negedge clk_i);
            // state now shows the previous row's edge
            if (r > 0) begin
                check_state(get_row(r - 1), $sformatf("after row %0d", r - 1));
                if (row[59:56] != prev_test) begin
                    finish_test(prev_test);
                end
            end
            check_flags(row, $sformatf("row %0d", r));
            record_loads(row);
            prev_test = row[59:56];
        end

        // one more edge to see the last row land
        @(posedge clk_i);
        drive_row(IDLE_ROW);
        @(negedge clk_i);
        if (n_rows > 0) begin
            check_state(get_row(n_rows - 1), $sformatf("after row %0d", n_rows - 1));
            finish_test(prev_test);
        end

        $display("tests passed %0d, tests failed %0d, mismatches %0d",
                 tests_passed, tests_failed, total_errs);
        if (tests_failed == 0 && total_errs == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== rtl/ibuf_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module ibuf_top (
    input  wire                      clk_i,
    input  wire                      rst_n_i,

    // control-flow and stall
    input  wire                      is_br_t_nt_i,
    input  wire                      is_resteer_i,
    input  wire                      is_init_i,
    input  wire                      stall_i,

    // fetch side, one line and pointer per bank
    input  wire ibuf_pkg::line_t     line_even_i,
    input  wire ibuf_pkg::line_t     line_odd_i,
    input  wire ibuf_pkg::fip_lsb_t  fip_e_lsb_i,
    input  wire ibuf_pkg::fip_lsb_t  fip_o_lsb_i,
    input  wire                      cache_miss_even_i,
    input  wire                      cache_miss_odd_i,
    input  wire                      even_wait_i,
    input  wire                      odd_wait_i,

    // decode side buffer pointer
    input  wire ibuf_pkg::bip_t      new_bip_i,
    input  wire ibuf_pkg::bip_t      old_bip_i,

    output wire ibuf_pkg::line_t     line_00_o,
    output wire ibuf_pkg::line_t     line_01_o,
    output wire ibuf_pkg::line_t     line_10_o,
    output wire ibuf_pkg::line_t     line_11_o,
    output wire ibuf_pkg::slot_vec_t line_valid_o,
    output wire                      even_loaded_o,
    output wire                      odd_loaded_o
);

    // per-slot enables, control to storage
    ibuf_pkg::slot_vec_t ld;
    ibuf_pkg::slot_vec_t inv;

    // enables are combinational off the registered valids
    ibuf_slot_control u_ctrl (
        .is_br_t_nt_i      (is_br_t_nt_i),
        .is_resteer_i      (is_resteer_i),
        .is_init_i         (is_init_i),
        .stall_i           (stall_i),
        .fip_e_lsb_i       (fip_e_lsb_i),
        .fip_o_lsb_i       (fip_o_lsb_i),
        .cache_miss_even_i (cache_miss_even_i),
        .cache_miss_odd_i  (cache_miss_odd_i),
        .even_wait_i       (even_wait_i),
        .odd_wait_i        (odd_wait_i),
        .new_bip_i         (new_bip_i),
        .old_bip_i         (old_bip_i),
        .valid_i           (line_valid_o),
        .ld_o              (ld),
        .inv_o             (inv),
        .even_loaded_o     (even_loaded_o),
        .odd_loaded_o      (odd_loaded_o)
    );

    // valids and lines land one edge after the enables
    ibuf_line_bank u_bank (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .line_even_i (line_even_i),
        .line_odd_i  (line_odd_i),
        .ld_i        (ld),
        .inv_i       (inv),
        .valid_o     (line_valid_o),
        .line_00_o   (line_00_o),
        .line_01_o   (line_01_o),
        .line_10_o   (line_10_o),
        .line_11_o   (line_11_o)
    );

endmodule

`default_nettype wire

// ==== rtl/ibuf_line_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ibuf_cfg.svh"

module ibuf_line_bank (
    input  wire                      clk_i,
    input  wire                      rst_n_i,

    // incoming lines, one per bank
    input  wire ibuf_pkg::line_t     line_even_i,
    input  wire ibuf_pkg::line_t     line_odd_i,

    // per-slot enables from the slot control
    input  wire ibuf_pkg::slot_vec_t ld_i,
    input  wire ibuf_pkg::slot_vec_t inv_i,

    output ibuf_pkg::slot_vec_t      valid_o,
    output ibuf_pkg::line_t          line_00_o,
    output ibuf_pkg::line_t          line_01_o,
    output ibuf_pkg::line_t          line_10_o,
    output ibuf_pkg::line_t          line_11_o
);

    ibuf_pkg::slot_vec_t valid_q;
    ibuf_pkg::line_t     line_q [`IBUF_SLOTS];

    // valid set on load, cleared on invalidate
    // the two never meet on one slot
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
        end else begin
            valid_q <= (valid_q | ld_i) & ~inv_i;
        end
    end

    // line storage, one register per slot
    for (genvar s = 0; s < `IBUF_SLOTS; s++) begin : g_slot
        ibuf_pkg::line_t line_in;

        // even slots (bit 0 clear) take the even line, odd slots the odd one
        assign line_in = (s % 2 == 0) ? line_even_i : line_odd_i;

        // written only on load, holds through invalidate
        always_ff @(posedge clk_i or negedge rst_n_i) begin
            if (!rst_n_i) begin
                line_q[s] <= '0;
            end else if (ld_i[s]) begin
                line_q[s] <= line_in;
            end
        end
    end

    assign valid_o = valid_q;

    // slot registers out to the fetch stage
    assign line_00_o = line_q[ibuf_pkg::SLOT_00];
    assign line_01_o = line_q[ibuf_pkg::SLOT_01];
    assign line_10_o = line_q[ibuf_pkg::SLOT_10];
    assign line_11_o = line_q[ibuf_pkg::SLOT_11];

endmodule

`default_nettype wire

// ==== rtl/ibuf_slot_control.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ibuf_cfg.svh"

module ibuf_slot_control (
    // control-flow events, any one of them flushes the buffer
    input  wire                  is_br_t_nt_i,
    input  wire                  is_resteer_i,
    input  wire                  is_init_i,
    input  wire                  stall_i,

    // fetch pointer low bits per bank
    input  wire ibuf_pkg::fip_lsb_t fip_e_lsb_i,
    input  wire ibuf_pkg::fip_lsb_t fip_o_lsb_i,

    // per-bank miss and wait
    input  wire                  cache_miss_even_i,
    input  wire                  cache_miss_odd_i,
    input  wire                  even_wait_i,
    input  wire                  odd_wait_i,

    // buffer index pointer, this cycle and last
    input  wire ibuf_pkg::bip_t  new_bip_i,
    input  wire ibuf_pkg::bip_t  old_bip_i,

    // current slot valids from the line bank
    input  wire ibuf_pkg::slot_vec_t valid_i,

    output ibuf_pkg::slot_vec_t  ld_o,
    output ibuf_pkg::slot_vec_t  inv_o,
    output logic                 even_loaded_o,
    output logic                 odd_loaded_o
);

    logic                flush;
    logic                even_ok;
    logic                odd_ok;
    ibuf_pkg::slot_e     even_slot;
    ibuf_pkg::slot_e     odd_slot;
    ibuf_pkg::slot_e     old_slot;
    ibuf_pkg::slot_vec_t even_hit;
    ibuf_pkg::slot_vec_t odd_hit;
    ibuf_pkg::slot_vec_t wrap_hit;
    ibuf_pkg::slot_vec_t inv_sel;
    logic [`IBUF_OFFS_W-1:0] new_offs;
    logic [`IBUF_OFFS_W-1:0] old_offs;
    logic                wrap;

    // any control-flow event
    assign flush = is_init_i | is_resteer_i | is_br_t_nt_i;

    // a bank may fill only with no miss, no wait and no flush
    assign even_ok = ~cache_miss_even_i & ~even_wait_i & ~flush;
    assign odd_ok  = ~cache_miss_odd_i & ~odd_wait_i & ~flush;

    // pointer bits read as slot names
    assign even_slot = ibuf_pkg::slot_e'(fip_e_lsb_i);
    assign odd_slot  = ibuf_pkg::slot_e'(fip_o_lsb_i);

    // even pointer decodes onto the even slots only
    // an odd slot name here selects nothing
    always_comb begin
        even_hit = '0;
        case (even_slot)
            ibuf_pkg::SLOT_00: even_hit[ibuf_pkg::SLOT_00] = 1'b1;
            ibuf_pkg::SLOT_10: even_hit[ibuf_pkg::SLOT_10] = 1'b1;
            default: even_hit = '0;
        endcase
    end

    // odd pointer onto the odd slots, same idea
    always_comb begin
        odd_hit = '0;
        case (odd_slot)
            ibuf_pkg::SLOT_01: odd_hit[ibuf_pkg::SLOT_01] = 1'b1;
            ibuf_pkg::SLOT_11: odd_hit[ibuf_pkg::SLOT_11] = 1'b1;
            default: odd_hit = '0;
        endcase
    end

    // load only into an empty slot, so a valid line is never overwritten
    assign ld_o = ~valid_i & ((even_hit & {`IBUF_SLOTS{even_ok}})
                            | (odd_hit & {`IBUF_SLOTS{odd_ok}}));

    // offset and slot fields of the buffer pointer
    assign new_offs = new_bip_i[`IBUF_OFFS_W-1:0];
    assign old_offs = old_bip_i[`IBUF_OFFS_W-1:0];
    assign old_slot = ibuf_pkg::slot_e'(old_bip_i[`IBUF_BIP_W-1:`IBUF_OFFS_W]);

    // offset went backwards, so the pointer left the old line
    assign wrap = (new_offs < old_offs);

    // one-hot of the line just consumed
    always_comb begin
        wrap_hit = '0;
        case (old_slot)
            ibuf_pkg::SLOT_00: wrap_hit[ibuf_pkg::SLOT_00] = 1'b1;
            ibuf_pkg::SLOT_01: wrap_hit[ibuf_pkg::SLOT_01] = 1'b1;
            ibuf_pkg::SLOT_10: wrap_hit[ibuf_pkg::SLOT_10] = 1'b1;
            ibuf_pkg::SLOT_11: wrap_hit[ibuf_pkg::SLOT_11] = 1'b1;
            default: wrap_hit = '0;
        endcase
    end

    // flush takes every slot, else the consumed line on a wrap
    always_comb begin
        if (flush) begin
            inv_sel = '1;
        end else if (wrap) begin
            inv_sel = wrap_hit;
        end else begin
            inv_sel = '0;
        end
    end

    // only valid slots are cleared, and a stall holds everything
    // valid-qualified, so inv and ld are exclusive per slot
    assign inv_o = inv_sel & valid_i & {`IBUF_SLOTS{~stall_i}};

    // per-bank "line taken this cycle"
    assign even_loaded_o = ld_o[ibuf_pkg::SLOT_00] | ld_o[ibuf_pkg::SLOT_10];
    assign odd_loaded_o  = ld_o[ibuf_pkg::SLOT_01] | ld_o[ibuf_pkg::SLOT_11];

endmodule

`default_nettype wire

// ==== rtl/ibuf_pkg.sv ====
`default_nettype none

`include "ibuf_cfg.svh"

package ibuf_pkg;

    // one cache line as it sits in a slot
    typedef logic [`IBUF_LINE_W-1:0] line_t;

    // one bit per slot, bit 0 is slot 00 and bit 3 is slot 11
    typedef logic [`IBUF_SLOTS-1:0] slot_vec_t;

    // fetch pointer low bits, names the target slot
    typedef logic [`IBUF_FIP_LSB_W-1:0] fip_lsb_t;

    // buffer index pointer, {slot, offset}
    typedef logic [`IBUF_BIP_W-1:0] bip_t;

    // slot identities
    // even lines use 00/10, odd lines use 01/11
    typedef enum logic [`IBUF_FIP_LSB_W-1:0] {
        SLOT_00 = 2'd0,
        SLOT_01 = 2'd1,
        SLOT_10 = 2'd2,
        SLOT_11 = 2'd3
    } slot_e;

endpackage

`default_nettype wire

// ==== include/ibuf_cfg.svh ====
`ifndef IBUF_CFG_SVH
`define IBUF_CFG_SVH

// bits per cache line held in one slot
`define IBUF_LINE_W 128

// slot count, two even slots and two odd slots
`define IBUF_SLOTS 4

// low bits of the even/odd fetch pointers, enough to name a slot
`define IBUF_FIP_LSB_W 2

// buffer index pointer, slot field on top of the byte offset
`define IBUF_BIP_W 6

// byte offset inside one 16-byte line
`define IBUF_OFFS_W 4

`endif
